// ==== Bender.yml ====
package:
  name: armCore

sources:
  - include_dirs:
      - .
    files:
      - armPkg.sv
      - aluUnit.sv
      - regFile.sv
      - pcUnit.sv
      - condUnit.sv
      - instrDecoder.sv
      - armCore.sv
      - target: simulation
        files:
          - armCoreTb.sv

// ==== aluUnit.sv ====
// Add, subtract, AND and OR with NZCV; C and V read as zero for the logical operations
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  wire logic [armPkg::dataWidth-1:0] a,
   input  wire logic [armPkg::dataWidth-1:0] b,
   input  wire armPkg::aluOp_e aluOp,
   output logic [armPkg::dataWidth-1:0] result,
   output armPkg::flags_t aluFlags
);

   logic isSub;
   logic isArith;
   logic [armPkg::dataWidth-1:0] bInv;
   logic [armPkg::dataWidth:0] sum;

   assign isSub = (aluOp == armPkg::aluSub);
   assign isArith = (aluOp == armPkg::aluAdd) || isSub;

   // One adder, subtract as a + ~b + 1
   assign bInv = isSub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bInv} + (armPkg::dataWidth + 1)'(isSub);

   always_comb
   begin
      case (aluOp)
         armPkg::aluAnd: result = a & b;
         armPkg::aluOrr: result = a | b;
         default: result = sum[armPkg::dataWidth-1:0];
      endcase
   end

   assign aluFlags.n = result[armPkg::dataWidth-1];
   assign aluFlags.z = (result == '0);
   assign aluFlags.c = isArith & sum[armPkg::dataWidth]; // No borrow gives C set on SUB

   // Operands of equal sign after inversion, result of the other sign
   assign aluFlags.v = isArith &
                       ~(a[armPkg::dataWidth-1] ^ b[armPkg::dataWidth-1] ^ isSub) &
                       (a[armPkg::dataWidth-1] ^ sum[armPkg::dataWidth-1]);

endmodule

`default_nettype wire

// ==== armCore.sv ====
// Single-cycle ARMv4 subset core; instr and readData must be combinational, pcReady low stalls all state
`timescale 1ns/1ps
`default_nettype none

module armCore #(
   parameter logic [armPkg::dataWidth-1:0] resetPc = '0
) (
   input  wire logic clk,
   input  wire logic reset,
   output logic [armPkg::dataWidth-1:0] pc,
   input  wire logic [armPkg::dataWidth-1:0] instr,
   output logic memWrite,
   output logic [armPkg::dataWidth-1:0] aluResult,
   output logic [armPkg::dataWidth-1:0] writeData,
   input  wire logic [armPkg::dataWidth-1:0] readData,
   input  wire logic pcReady
);

   logic regWriteReq;
   logic memWriteReq;
   logic branch;
   logic [1:0] flagWrite;
   armPkg::aluOp_e aluOp;
   logic aluSrcImm;
   logic memToReg;
   logic regSrcStore;
   logic [armPkg::dataWidth-1:0] extImm;
   armPkg::flags_t aluFlags;
   logic regWrite;
   logic takeBranch;
   logic commit;
   logic [armPkg::dataWidth-1:0] pcPlus8;
   logic [armPkg::dataWidth-1:0] srcA;
   logic [armPkg::dataWidth-1:0] srcB;
   logic [armPkg::dataWidth-1:0] result;
   logic [armPkg::regAddrWidth-1:0] readAddrA;
   logic [armPkg::regAddrWidth-1:0] readAddrB;

   // B adds its offset to R15
   assign readAddrA = branch ? armPkg::regAddrWidth'(armPkg::pcRegIndex) : instr[19:16];
   assign readAddrB = regSrcStore ? instr[15:12] : instr[3:0]; // rd is the STR data

   assign srcB = aluSrcImm ? extImm : writeData;
   assign result = memToReg ? readData : aluResult;

   instrDecoder u_decoder (
      .instr(instr),
      .regWriteReq(regWriteReq),
      .memWriteReq(memWriteReq),
      .branch(branch),
      .flagWrite(flagWrite),
      .aluOp(aluOp),
      .aluSrcImm(aluSrcImm),
      .memToReg(memToReg),
      .regSrcStore(regSrcStore),
      .extImm(extImm)
   );

   condUnit u_cond (
      .clk(clk),
      .reset(reset),
      .cond(instr[31:28]),
      .aluFlags(aluFlags),
      .flagWrite(flagWrite),
      .regWriteReq(regWriteReq),
      .memWriteReq(memWriteReq),
      .branch(branch),
      .pcReady(pcReady),
      .regWrite(regWrite),
      .memWrite(memWrite),
      .takeBranch(takeBranch),
      .commit(commit)
   );

   pcUnit #(.resetPc(resetPc)) u_pc (
      .clk(clk),
      .reset(reset),
      .commit(commit),
      .takeBranch(takeBranch),
      .branchTarget(aluResult), // PC+8 plus offset from the ALU
      .pc(pc),
      .pcPlus8(pcPlus8)
   );

   regFile u_regs (
      .clk(clk),
      .writeEn(regWrite),
      .readAddrA(readAddrA),
      .readAddrB(readAddrB),
      .writeAddr(instr[15:12]),
      .writeData(result),
      .pcPlus8(pcPlus8),
      .readDataA(srcA),
      .readDataB(writeData)
   );

   aluUnit u_alu (
      .a(srcA),
      .b(srcB),
      .aluOp(aluOp),
      .result(aluResult),
      .aluFlags(aluFlags)
   );

endmodule

`default_nettype wire

// ==== tbProgram.svh ====
// Test program and expected stores; the ROM holds 256 words and data memory 64 words, both word indexed
`ifndef TBPROGRAM_SVH
`define TBPROGRAM_SVH

localparam int romWords = 256;
localparam int dataWords = 64;
localparam int maxStores = 96;
localparam logic [3:0] al = armPkg::condAlways;

logic [31:0] rom [0:romWords-1];
int progLen;
logic [31:0] expAddr [0:maxStores-1];
logic [31:0] expData [0:maxStores-1];
int expTest [0:maxStores-1];
int expCount;

function automatic logic [31:0] dpWord(input logic [3:0] cond, input logic [3:0] func,
   input logic immBit, input logic s, input logic [3:0] rn, input logic [3:0] rd,
   input logic [7:0] src2);
   return {cond, 2'b00, immBit, func, s, rn, rd, 4'b0000, src2};
endfunction

function automatic logic [31:0] memWord(input logic [3:0] cond, input logic l,
   input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] imm12);
   return {cond, 2'b01, 5'b01100, l, rn, rd, imm12}; // Plain pre-indexed, offset added
endfunction

function automatic logic [31:0] brWord(input logic [3:0] cond, input int offset);
   logic [31:0] off;
   off = offset;
   return {cond, 2'b10, 1'b1, 1'b0, off[23:0]};
endfunction

// Data memory preload, also the source of the large operands
function automatic logic [31:0] fillWord(input int index);
   return 32'h8000_0000 | (index << 2);
endfunction

// {n, z, c, v} of a - b by the ARM subtract rules
function automatic logic [3:0] subFlags(input logic [31:0] a, input logic [31:0] b);
   logic [31:0] d;
   d = a - b;
   return {d[31], d == 32'd0, a >= b, (a[31] != b[31]) && (d[31] != a[31])};
endfunction

function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
   logic n, z, c, v;
   {n, z, c, v} = f;
   case (cond)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return c;
      4'h3: return !c;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return c && !z;
      4'h9: return !c || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && (n == v);
      4'hD: return z || (n != v);
      default: return 1'b1;
   endcase
endfunction

task automatic emit(input logic [31:0] word);
   rom[progLen] = word;
   progLen++;
endtask

task automatic expectStore(input logic [31:0] addr, input logic [31:0] data, input int test);
   expAddr[expCount] = addr;
   expData[expCount] = data;
   expTest[expCount] = test;
   expCount++;
endtask

task automatic loadProgram();
   logic [3:0] rnList [0:3];
   logic [3:0] rmList [0:3];
   logic [31:0] aList [0:3];
   logic [31:0] bList [0:3];
   logic [3:0] f;
   int loopAddr;
   progLen = 0;
   expCount = 0;
   rnList = '{4'd1, 4'd1, 4'd2, 4'd8};
   rmList = '{4'd2, 4'd1, 4'd1, 4'd9};
   aList = '{32'd200, 32'd200, 32'd100, fillWord(63)};
   bList = '{32'd100, 32'd200, 32'd200, fillWord(63) + fillWord(63)};

   // Arithmetic, r0 cleared first since registers have no reset
   emit(dpWord(al, armPkg::funcAnd, 1, 0, 0, 0, 8'h00));
   emit(dpWord(al, armPkg::funcAdd, 1, 0, 0, 1, 8'd200));
   emit(dpWord(al, armPkg::funcAdd, 1, 0, 0, 2, 8'd100));
   emit(dpWord(al, armPkg::funcAdd, 0, 0, 1, 3, 8'd2));
   emit(memWord(al, 0, 0, 3, 12'h000));
   expectStore(32'h00, 32'd300, 1);
   emit(dpWord(al, armPkg::funcSub, 0, 0, 2, 4, 8'd1));
   emit(memWord(al, 0, 0, 4, 12'h004));
   expectStore(32'h04, 32'd100 - 32'd200, 1);
   emit(dpWord(al, armPkg::funcSub, 1, 0, 1, 5, 8'd255));
   emit(dpWord(al, armPkg::funcAdd, 0, 0, 5, 5, 8'd4));
   emit(memWord(al, 0, 0, 5, 12'h008));
   expectStore(32'h08, (32'd200 - 32'd255) + (32'd100 - 32'd200), 1);

   // Logical ops, then proof that ANDS/ORRS keep C and V
   emit(dpWord(al, armPkg::funcOrr, 1, 0, 0, 6, 8'hF0));
   emit(dpWord(al, armPkg::funcOrr, 0, 0, 6, 6, 8'd1));
   emit(memWord(al, 0, 0, 6, 12'h00C));
   expectStore(32'h0C, 32'hF0 | 32'd200, 2);
   emit(dpWord(al, armPkg::funcAnd, 1, 0, 6, 7, 8'h3C));
   emit(memWord(al, 0, 0, 7, 12'h010));
   expectStore(32'h10, (32'hF0 | 32'd200) & 32'h3C, 2);
   emit(memWord(al, 1, 0, 8, 12'h0FC));
   emit(dpWord(al, armPkg::funcAdd, 0, 1, 8, 9, 8'd8)); // Two negatives, C and V set
   emit(dpWord(al, armPkg::funcAnd, 1, 1, 9, 10, 8'h00));
   emit(memWord(armPkg::condCs, 0, 0, 1, 12'h014));
   expectStore(32'h14, 32'd200, 2);
   emit(memWord(armPkg::condVs, 0, 0, 2, 12'h018));
   expectStore(32'h18, 32'd100, 2);
   emit(memWord(armPkg::condEq, 0, 0, 6, 12'h01C));
   expectStore(32'h1C, 32'hF8, 2);
   emit(dpWord(al, armPkg::funcOrr, 1, 1, 0, 10, 8'h01));
   emit(memWord(armPkg::condCs, 0, 0, 3, 12'h020));
   expectStore(32'h20, 32'd300, 2);
   emit(memWord(armPkg::condMi, 0, 0, 3, 12'h024)); // N clear, no store

   // Every condition after four SUBS flag states
   for (int s = 0; s < 4; s++)
   begin
      emit(dpWord(al, armPkg::funcSub, 0, 1, rnList[s], 11, {4'b0, rmList[s]}));
      emit(dpWord(al, armPkg::funcAdd, 1, 0, 0, 12, 8'((s + 1) * 16)));
      f = subFlags(aList[s], bList[s]);
      for (int c = 0; c < 14; c++)
      begin
         emit(memWord(4'(c), 0, 0, 12, 12'(32'h40 + c * 4)));
         if (condHolds(4'(c), f))
            expectStore(32'h40 + c * 4, (s + 1) * 16, 3);
      end
   end

   // Load back a word stored by the program
   emit(memWord(al, 0, 0, 3, 12'h0E0));
   expectStore(32'hE0, 32'd300, 4);
   emit(dpWord(al, armPkg::funcAdd, 1, 0, 0, 13, 8'd0));
   emit(memWord(al, 1, 2, 13, 12'h07C)); // 100 + 0x7C
   emit(memWord(al, 0, 0, 13, 12'h0E4));
   expectStore(32'hE4, 32'd300, 4);

   // Taken branch over two stores, then a false BEQ
   emit(brWord(al, 1));
   emit(memWord(al, 0, 0, 3, 12'h0F0));
   emit(memWord(al, 0, 0, 3, 12'h0F0));
   emit(memWord(al, 0, 0, 1, 12'h0E8));
   expectStore(32'hE8, 32'd200, 5);
   emit(brWord(armPkg::condEq, 1));
   emit(memWord(al, 0, 0, 2, 12'h0EC));
   expectStore(32'hEC, 32'd100, 5);
   emit(memWord(al, 0, 0, 6, 12'h0F0));
   expectStore(32'hF0, 32'hF8, 5);

   loopAddr = progLen * 4;
   emit(brWord(al, -2));
   // Any stray fetch branches to the final loop
   for (int a = progLen; a < romWords; a++)
      rom[a] = brWord(al, (loopAddr - (a * 4 + 8)) / 4);
endtask

`endif

// ==== armCoreTb.sv ====
// Testbench for armCore; expects single-cycle behaviour and checks the store stream in order
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;

   `include "tbProgram.svh"

   logic clk;
   logic reset;
   logic pcReady;
   logic [31:0] pc;
   logic [31:0] instr;
   logic memWrite;
   logic [31:0] aluResult;
   logic [31:0] writeData;
   logic [31:0] readData;

   logic [31:0] dataMem [0:dataWords-1];
   logic [31:0] lfsr = 32'h4a21d5a2;
   logic [31:0] heldPc;
   int storeIdx = 0;
   int errorCount = 0;
   int testErrors [1:5];
   int testStores [1:5];
   logic reportPending = 1'b0;
   int reportTest = 0;
   string testName [1:5];

   armCore #(.resetPc(32'h0)) DUT (
      .clk(clk),
      .reset(reset),
      .pc(pc),
      .instr(instr),
      .memWrite(memWrite),
      .aluResult(aluResult),
      .writeData(writeData),
      .readData(readData),
      .pcReady(pcReady)
   );

   assign instr = rom[pc[9:2]];
   assign readData = dataMem[aluResult[7:2]];

   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      if (memWrite)
         dataMem[aluResult[7:2]] <= writeData;
   end

   always @(posedge clk)
   begin
      heldPc <= pc; // PC of the cycle just ended
   end

   // Galois form with taps of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] stepLfsr(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb)
         s = s ^ 32'h8020_0003;
      return s;
   endfunction

   always @(posedge clk)
   begin
      pcReady <= lfsr[0]; // Zero bit stalls
      lfsr <= stepLfsr(lfsr);
   end

   always @(posedge clk)
   begin
      if (!reset && memWrite)
      begin
         if (storeIdx < expCount)
         begin
            testStores[expTest[storeIdx]]++;
            if (storeIdx == expCount - 1 || expTest[storeIdx + 1] != expTest[storeIdx])
            begin
               reportTest <= expTest[storeIdx];
               reportPending <= 1'b1;
            end
         end
         storeIdx <= storeIdx + 1;
      end
   end

   always @(negedge clk)
   begin
      if (reportPending)
      begin
         $display("Test %0d (%s) finished: %0d stores, %0d errors", reportTest,
                  testName[reportTest], testStores[reportTest], testErrors[reportTest]);
         reportPending <= 1'b0;
      end
   end

   assert property (@(posedge clk) disable iff (reset)
                    memWrite && storeIdx < expCount |-> aluResult == expAddr[storeIdx])
   else
   begin
      errorCount++;
      testErrors[expTest[$sampled(storeIdx)]]++;
      $display("MISMATCH at %0t: aluResult expected %h got %h", $time,
               expAddr[$sampled(storeIdx)], $sampled(aluResult));
   end

   assert property (@(posedge clk) disable iff (reset)
                    memWrite && storeIdx < expCount |-> writeData == expData[storeIdx])
   else
   begin
      errorCount++;
      testErrors[expTest[$sampled(storeIdx)]]++;
      $display("MISMATCH at %0t: writeData expected %h got %h", $time,
               expData[$sampled(storeIdx)], $sampled(writeData));
   end

   assert property (@(posedge clk) disable iff (reset) memWrite |-> storeIdx < expCount)
   else
   begin
      errorCount++;
      $display("Unexpected extra store at %0t to address %h", $time, $sampled(aluResult));
   end

   assert property (@(posedge clk) reset |-> !memWrite)
   else
   begin
      errorCount++;
      $display("memWrite was high during reset at %0t", $time);
   end

   assert property (@(posedge clk) reset |-> pc == 32'h0)
   else
   begin
      errorCount++;
      $display("MISMATCH at %0t: pc expected %h got %h", $time, 32'h0, $sampled(pc));
   end

   // A stalled cycle leaves the PC where it was
   assert property (@(posedge clk) disable iff (reset) !pcReady |=> pc == heldPc)
   else
   begin
      errorCount++;
      $display("MISMATCH at %0t: pc expected %h got %h", $time, $sampled(heldPc),
               $sampled(pc));
   end

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      pcReady = 1'b0;
      testName = '{"arithmetic", "logical flags", "conditions", "load", "branch"};
      for (int t = 1; t <= 5; t++)
      begin
         testErrors[t] = 0;
         testStores[t] = 0;
      end
      loadProgram();
      for (int i = 0; i < dataWords; i++)
         dataMem[i] = fillWord(i);
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      wait (storeIdx >= expCount);
      repeat (40) @(posedge clk); // Room for any stray store
      $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expCount, errorCount);
      if (errorCount == 0 && storeIdx == expCount)
         $display("Simulation finished: PASS");
      else
      begin
         if (storeIdx != expCount)
            $display("Store count differs from the expected table");
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // Four cycles per instruction covers the random stalls
   initial
   begin
      #1;
      repeat (progLen * 4 + 100) @(posedge clk);
      $display("Timeout: only %0d of %0d stores arrived", storeIdx, expCount);
      $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expCount, errorCount);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== armPkg.sv ====
// Shared widths and encodings; only the ADD/SUB/AND/ORR, LDR/STR and B subset of ARMv4 is encoded
`default_nettype none

package armPkg;

   parameter int dataWidth = 32;
   parameter int regAddrWidth = 4;
   parameter int pcRegIndex = 15; // R15 reads as PC+8

   // Instruction bits 27:26
   parameter logic [1:0] opDataProc = 2'b00;
   parameter logic [1:0] opMemory = 2'b01;
   parameter logic [1:0] opBranch = 2'b10;

   // Data processing function field, bits 24:21
   parameter logic [3:0] funcAdd = 4'b0100;
   parameter logic [3:0] funcSub = 4'b0010;
   parameter logic [3:0] funcAnd = 4'b0000;
   parameter logic [3:0] funcOrr = 4'b1100;

   parameter logic [3:0] condEq = 4'b0000;
   parameter logic [3:0] condNe = 4'b0001;
   parameter logic [3:0] condCs = 4'b0010;
   parameter logic [3:0] condCc = 4'b0011;
   parameter logic [3:0] condMi = 4'b0100;
   parameter logic [3:0] condPl = 4'b0101;
   parameter logic [3:0] condVs = 4'b0110;
   parameter logic [3:0] condVc = 4'b0111;
   parameter logic [3:0] condHi = 4'b1000; // C set and Z clear
   parameter logic [3:0] condLs = 4'b1001;
   parameter logic [3:0] condGe = 4'b1010; // N equals V
   parameter logic [3:0] condLt = 4'b1011;
   parameter logic [3:0] condGt = 4'b1100;
   parameter logic [3:0] condLe = 4'b1101;
   parameter logic [3:0] condAlways = 4'b1110;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOrr} aluOp_e;

   typedef enum logic [1:0] {immSel8, immSel12, immSel24} immSel_e;

   typedef struct packed {
      logic n;
      logic z;
      logic c;
      logic v;
   } flags_t;

   // Same 32-bit word seen through the three supported formats
   typedef union packed {
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic immBit;     // Second operand is imm8
         logic [3:0] func;
         logic s;          // Update flags
         logic [3:0] rn;
         logic [3:0] rd;
         logic [3:0] rot;  // Rotate amount, not supported
         logic [7:0] src2; // imm8 or {4'b0, rm}
      } dp;
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic [4:0] ctrl; // I P U B W, only the plain offset form is used
         logic l;          // 1 for LDR
         logic [3:0] rn;
         logic [3:0] rd;
         logic [11:0] imm12;
      } mem;
      struct packed {
         logic [3:0] cond;
         logic [1:0] op;
         logic brFlag;     // Always 1 for B
         logic link;
         logic [23:0] imm24;
      } br;
   } instrWord_u;

endpackage

`default_nettype wire

// ==== condUnit.sv ====
// Flag register and condition check; every write is gated by the condition and by pcReady
`timescale 1ns/1ps
`default_nettype none

module condUnit (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic [3:0] cond,
   input  wire armPkg::flags_t aluFlags,
   input  wire logic [1:0] flagWrite,
   input  wire logic regWriteReq,
   input  wire logic memWriteReq,
   input  wire logic branch,
   input  wire logic pcReady,
   output logic regWrite,
   output logic memWrite,
   output logic takeBranch,
   output logic commit
);

   armPkg::flags_t flags;
   logic condEx;
   logic ge;
   logic doIt;

   assign commit = pcReady & ~reset; // Nothing commits while in reset
   assign doIt = condEx & commit;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags.n <= 1'b0;
         flags.z <= 1'b0;
      end
      else if (flagWrite[1] && doIt)
      begin
         flags.n <= aluFlags.n;
         flags.z <= aluFlags.z;
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         flags.c <= 1'b0;
         flags.v <= 1'b0;
      end
      else if (flagWrite[0] && doIt)
      begin
         flags.c <= aluFlags.c;
         flags.v <= aluFlags.v;
      end
   end

   assign ge = (flags.n == flags.v);

   always_comb
   begin
      case (cond)
         armPkg::condEq: condEx = flags.z;
         armPkg::condNe: condEx = ~flags.z;
         armPkg::condCs: condEx = flags.c;
         armPkg::condCc: condEx = ~flags.c;
         armPkg::condMi: condEx = flags.n;
         armPkg::condPl: condEx = ~flags.n;
         armPkg::condVs: condEx = flags.v;
         armPkg::condVc: condEx = ~flags.v;
         armPkg::condHi: condEx = flags.c & ~flags.z;
         armPkg::condLs: condEx = ~flags.c | flags.z;
         armPkg::condGe: condEx = ge;
         armPkg::condLt: condEx = ~ge;
         armPkg::condGt: condEx = ~flags.z & ge;
         armPkg::condLe: condEx = flags.z | ~ge;
         armPkg::condAlways: condEx = 1'b1;
         default: condEx = 1'b0; // 1111 never executes
      endcase
   end

   assign regWrite = regWriteReq & doIt;
   assign memWrite = memWriteReq & doIt;
   assign takeBranch = branch & doIt;

   assert property (@(posedge clk) disable iff (reset) memWrite |-> pcReady)
      else $error("Store issued while stalled");

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
// Main and ALU decode plus immediate extension; unsupported encodings and writes to R15 become no-ops
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  wire armPkg::instrWord_u instr,
   output logic regWriteReq,
   output logic memWriteReq,
   output logic branch,
   output logic [1:0] flagWrite, // {NZ, CV}
   output armPkg::aluOp_e aluOp,
   output logic aluSrcImm,
   output logic memToReg,
   output logic regSrcStore,
   output logic [armPkg::dataWidth-1:0] extImm
);

   armPkg::immSel_e immSel;

   always_comb
   begin
      regWriteReq = 1'b0;
      memWriteReq = 1'b0;
      branch = 1'b0;
      flagWrite = 2'b00;
      aluOp = armPkg::aluAdd; // Address and branch target use add
      aluSrcImm = 1'b0;
      memToReg = 1'b0;
      regSrcStore = 1'b0;
      immSel = armPkg::immSel8;

      case (instr.dp.op)
         armPkg::opDataProc:
         begin
            regWriteReq = 1'b1;
            aluSrcImm = instr.dp.immBit;
            case (instr.dp.func)
               armPkg::funcAdd: aluOp = armPkg::aluAdd;
               armPkg::funcSub: aluOp = armPkg::aluSub;
               armPkg::funcAnd: aluOp = armPkg::aluAnd;
               armPkg::funcOrr: aluOp = armPkg::aluOrr;
               default: regWriteReq = 1'b0; // Other functions do nothing
            endcase
            flagWrite[1] = instr.dp.s & regWriteReq;
            // Logical ops keep C and V
            flagWrite[0] = flagWrite[1] &
                           (aluOp == armPkg::aluAdd || aluOp == armPkg::aluSub);
         end
         armPkg::opMemory:
         begin
            aluSrcImm = 1'b1;
            immSel = armPkg::immSel12;
            memToReg = instr.mem.l;
            regWriteReq = instr.mem.l;
            memWriteReq = ~instr.mem.l;
            regSrcStore = ~instr.mem.l;
         end
         armPkg::opBranch:
         begin
            branch = instr.br.brFlag & ~instr.br.link; // BL not supported
            aluSrcImm = 1'b1;
            immSel = armPkg::immSel24;
         end
         default:
         begin
            regWriteReq = 1'b0;
         end
      endcase

      // R15 is never a destination
      if (instr.dp.rd == armPkg::regAddrWidth'(armPkg::pcRegIndex))
         regWriteReq = 1'b0;
   end

   always_comb
   begin
      case (immSel)
         armPkg::immSel12: extImm = {20'b0, instr.mem.imm12};
         armPkg::immSel24: extImm = {{6{instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default: extImm = {24'b0, instr.dp.src2};
      endcase
   end

   // A known word in a supported format must give known controls
   always_comb
   begin
      if (!$isunknown(instr) && instr.dp.op != 2'b11)
         assert final (!$isunknown({regWriteReq, memWriteReq, branch, flagWrite, aluOp,
                                    aluSrcImm, memToReg, regSrcStore, extImm}))
         else $error("Decoder gave unknown controls for %h", instr);
   end

endmodule

`default_nettype wire

// ==== pcUnit.sv ====
// Program counter; resetPc must be word aligned and the PC only moves on commit
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
   parameter logic [armPkg::dataWidth-1:0] resetPc = '0
) (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic commit,
   input  wire logic takeBranch,
   input  wire logic [armPkg::dataWidth-1:0] branchTarget,
   output logic [armPkg::dataWidth-1:0] pc,
   output logic [armPkg::dataWidth-1:0] pcPlus8
);

   logic [armPkg::dataWidth-1:0] pcPlus4;
   logic [armPkg::dataWidth-1:0] pcNext;

   assign pcPlus4 = pc + armPkg::dataWidth'(4);
   assign pcPlus8 = pc + armPkg::dataWidth'(8); // R15 view
   assign pcNext = takeBranch ? branchTarget : pcPlus4;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         pc <= resetPc;
      else if (commit)
         pc <= pcNext;
   end

   assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("PC lost word alignment: %h", pc);

endmodule

`default_nettype wire

// ==== regFile.sv ====
// Fifteen registers without reset; index 15 reads PC+8 and is never written
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire logic clk,
   input  wire logic writeEn,
   input  wire logic [armPkg::regAddrWidth-1:0] readAddrA,
   input  wire logic [armPkg::regAddrWidth-1:0] readAddrB,
   input  wire logic [armPkg::regAddrWidth-1:0] writeAddr,
   input  wire logic [armPkg::dataWidth-1:0] writeData,
   input  wire logic [armPkg::dataWidth-1:0] pcPlus8,
   output logic [armPkg::dataWidth-1:0] readDataA,
   output logic [armPkg::dataWidth-1:0] readDataB
);

   logic [armPkg::dataWidth-1:0] regs [0:armPkg::pcRegIndex-1];

   always_ff @(posedge clk)
   begin
      if (writeEn)
         regs[writeAddr] <= writeData;
   end

   assign readDataA = (readAddrA == armPkg::pcRegIndex) ? pcPlus8 : regs[readAddrA];
   assign readDataB = (readAddrB == armPkg::pcRegIndex) ? pcPlus8 : regs[readAddrB];

   // Decoder must filter every R15 destination
   assert property (@(posedge clk) writeEn |-> writeAddr != armPkg::pcRegIndex)
      else $error("Write to R15 reached the register file");

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
armPkg.sv
aluUnit.sv
regFile.sv
pcUnit.sv
condUnit.sv
instrDecoder.sv
armCore.sv
armCoreTb.sv
